// File: sim.f
common/riscv_isa_pkg.sv
common/ctrl_pkg.sv
common/decode_if.sv
decode/instr_decoder.sv
sequencer/control_fsm.sv
sequencer/ctrl_signal_gen.sv
src/control_unit.sv
bench/control_unit_assertions.sv
bench/control_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = control_unit_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/control_unit_tb.sv
`default_nettype none

module control_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import riscv_isa_pkg::*;
    import ctrl_pkg::*;

    localparam int N_TESTS    = 26;
    localparam int MAX_CYCLES = 10 * N_TESTS + 20;

    logic       CLK;
    logic       RST;
    instr_t     instr;
    logic       alu_zero;
    logic       alu_less;
    logic       pc_write;
    logic       pc_sel;
    logic       ir_load;
    logic       a_write;
    logic       b_write;
    logic       alu_out_write;
    logic       mdr_write;
    logic       mem_write;
    logic       reg_write;
    logic       datapath_reset;
    alu_op_t    alu_op;
    mux_a_sel_t alu_a_sel;
    mux_b_sel_t alu_b_sel;
    wb_sel_t    wb_sel;
    store_sel_t store_sel;

    // Test table, one entry per instruction
    string      test_name [N_TESTS];
    instr_t     test_instr [N_TESTS];
    logic       test_zero [N_TESTS];
    logic       test_less [N_TESTS];
    int         exp_cycles [N_TESTS];
    int         exp_regw [N_TESTS];
    wb_sel_t    exp_wb [N_TESTS];
    int         exp_memw [N_TESTS];
    store_sel_t exp_st [N_TESTS];
    int         exp_mdr [N_TESTS];
    int         exp_pcw [N_TESTS];
    alu_op_t    exp_op [N_TESTS];

    int n_tests     = 0;
    int row_errors  = 0;
    int failures    = 0;
    int tests_run   = 0;
    int cycle_count = 0;

    control_unit control_unit_inst (
        .CLK            (CLK),
        .RST            (RST),
        .instr          (instr),
        .alu_zero       (alu_zero),
        .alu_less       (alu_less),
        .pc_write       (pc_write),
        .pc_sel         (pc_sel),
        .ir_load        (ir_load),
        .a_write        (a_write),
        .b_write        (b_write),
        .alu_out_write  (alu_out_write),
        .mdr_write      (mdr_write),
        .mem_write      (mem_write),
        .reg_write      (reg_write),
        .datapath_reset (datapath_reset),
        .alu_op         (alu_op),
        .alu_a_sel      (alu_a_sel),
        .alu_b_sel      (alu_b_sel),
        .wb_sel         (wb_sel),
        .store_sel      (store_sel)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic add_test(input string name, input opcode_t opc, input funct3_t f3,
                            input funct7_t f7, input int zero, input int less,
                            input int cycles, input int regw, input wb_sel_t wb,
                            input int memw, input store_sel_t st, input int mdr,
                            input int pcw, input alu_op_t op);
        instr_t word;
        word = $urandom; // Registers and immediates
        word[6:0] = opc;
        if (opc != OPC_LUI) begin
            word[14:12] = f3;
        end
        if (opc == OPC_OP) begin
            word[31:25] = f7;
        end
        test_name[n_tests]  = name;
        test_instr[n_tests] = word;
        test_zero[n_tests]  = (zero != 0);
        test_less[n_tests]  = (less != 0);
        exp_cycles[n_tests] = cycles;
        exp_regw[n_tests]   = regw;
        exp_wb[n_tests]     = wb;
        exp_memw[n_tests]   = memw;
        exp_st[n_tests]     = st;
        exp_mdr[n_tests]    = mdr;
        exp_pcw[n_tests]    = pcw;
        exp_op[n_tests]     = op;
        n_tests++;
    endtask

    task automatic build_table();
        add_test("add", OPC_OP, F3_ADD, FUNCT7_BASE, 0, 0, 5, 1, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_ADD);
        add_test("sub", OPC_OP, F3_ADD, FUNCT7_SUB, 1, 0, 5, 1, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_SUB);
        add_test("and", OPC_OP, F3_AND, FUNCT7_BASE, 0, 1, 5, 1, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_AND);
        add_test("slt less", OPC_OP, F3_SLT, FUNCT7_BASE, 0, 1, 5, 1, WB_ONE, 0, ST_D, 0, 1, ALU_SLT);
        add_test("slt ge", OPC_OP, F3_SLT, FUNCT7_BASE, 0, 0, 5, 1, WB_ZERO, 0, ST_D, 0, 1, ALU_SLT);
        add_test("addi", OPC_OP_IMM, F3_ADD, '0, 0, 0, 5, 1, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_ADD);
        add_test("slti less", OPC_OP_IMM, F3_SLT, '0, 0, 1, 5, 1, WB_ONE, 0, ST_D, 0, 1, ALU_SLT);
        add_test("slti ge", OPC_OP_IMM, F3_SLT, '0, 1, 0, 5, 1, WB_ZERO, 0, ST_D, 0, 1, ALU_SLT);
        add_test("ld", OPC_LOAD, F3_LD, '0, 0, 0, 7, 1, WB_LD, 0, ST_D, 1, 1, ALU_ADD);
        add_test("lb", OPC_LOAD, F3_LB, '0, 0, 0, 7, 1, WB_LB, 0, ST_D, 1, 1, ALU_ADD);
        add_test("lh", OPC_LOAD, F3_LH, '0, 0, 0, 7, 1, WB_LH, 0, ST_D, 1, 1, ALU_ADD);
        add_test("lw", OPC_LOAD, F3_LW, '0, 0, 0, 7, 1, WB_LW, 0, ST_D, 1, 1, ALU_ADD);
        add_test("lbu", OPC_LOAD, F3_LBU, '0, 0, 0, 7, 1, WB_LBU, 0, ST_D, 1, 1, ALU_ADD);
        add_test("lhu", OPC_LOAD, F3_LHU, '0, 0, 0, 7, 1, WB_LHU, 0, ST_D, 1, 1, ALU_ADD);
        add_test("lwu", OPC_LOAD, F3_LWU, '0, 0, 0, 7, 1, WB_LWU, 0, ST_D, 1, 1, ALU_ADD);
        add_test("sd", OPC_STORE, F3_SD, '0, 0, 0, 7, 0, WB_ALU_OUT, 1, ST_D, 1, 1, ALU_ADD);
        add_test("sw", OPC_STORE, F3_SW, '0, 0, 0, 7, 0, WB_ALU_OUT, 1, ST_W, 1, 1, ALU_ADD);
        add_test("sh", OPC_STORE, F3_SH, '0, 0, 0, 7, 0, WB_ALU_OUT, 1, ST_H, 1, 1, ALU_ADD);
        add_test("sb", OPC_STORE, F3_SB, '0, 0, 0, 7, 0, WB_ALU_OUT, 1, ST_B, 1, 1, ALU_ADD);
        add_test("beq taken", OPC_BRANCH, F3_BEQ, '0, 1, 0, 4, 0, WB_ALU_OUT, 0, ST_D, 0, 2, ALU_SUB);
        add_test("beq fall", OPC_BRANCH, F3_BEQ, '0, 0, 0, 4, 0, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_SUB);
        add_test("bne taken", OPC_BRANCH, F3_BNE, '0, 0, 0, 4, 0, WB_ALU_OUT, 0, ST_D, 0, 2, ALU_SUB);
        add_test("bne fall", OPC_BRANCH, F3_BNE, '0, 1, 0, 4, 0, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_SUB);
        add_test("jalr", OPC_JALR, F3_JALR, '0, 0, 0, 5, 1, WB_PC, 0, ST_D, 0, 2, ALU_ADD);
        add_test("lui", OPC_LUI, '0, '0, 0, 0, 5, 1, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_ADD);
        add_test("illegal", 7'b1111111, '0, '0, 0, 0, 4, 0, WB_ALU_OUT, 0, ST_D, 0, 1, ALU_NOP);
    endtask

    task automatic check_value(input string test, input string what, input int expected,
                               input int actual);
        assert (actual == expected) else begin
            $display("error %s %s expected %0d actual %0d", test, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic report_test(input string test);
        tests_run++;
        if (row_errors == 0) begin
            $display("test %s ok", test);
        end else begin
            $display("test %s has %0d errors", test, row_errors);
            failures++;
        end
        row_errors = 0;
    endtask

    initial begin
        int         cycles;
        int         pc_writes;
        int         reg_writes;
        int         mem_writes;
        int         mdr_writes;
        int         reset_cycles;
        int         same_sel_writes;
        logic       early_write;
        logic       ab_after;
        logic       exec_aow;
        logic       fetch_pc_sel;
        mux_a_sel_t fetch_a_sel;
        mux_b_sel_t fetch_b_sel;
        wb_sel_t    seen_wb;
        store_sel_t seen_st;
        alu_op_t    exec_op;

        RST      <= 1'b1;
        instr    <= '0;
        alu_zero <= 1'b0;
        alu_less <= 1'b0;
        void'($urandom(19));
        build_table();
        repeat (2) @(posedge CLK);
        RST <= 1'b0;

        // Up to the first fetch
        reset_cycles = 0;
        early_write  = 1'b0;
        @(negedge CLK);
        while (!ir_load) begin
            if (datapath_reset) reset_cycles++;
            if (pc_write || a_write || b_write || alu_out_write || mdr_write || mem_write
                || reg_write) early_write = 1'b1;
            @(negedge CLK);
        end
        assert (reset_cycles > 0) else begin
            $display("datapath_reset did not pulse before the first ir_load");
            row_errors++;
        end
        assert (!early_write) else begin
            $display("a write enable was high before the first ir_load");
            row_errors++;
        end
        report_test("reset");

        for (int i = 0; i < N_TESTS; i++) begin
            cycles          = 1;
            pc_writes       = pc_write ? 1 : 0;
            reg_writes      = 0;
            mem_writes      = 0;
            mdr_writes      = 0;
            same_sel_writes = 0;
            ab_after        = 1'b0;
            exec_aow        = 1'b0;
            fetch_pc_sel    = pc_sel;
            fetch_a_sel     = alu_a_sel;
            fetch_b_sel     = alu_b_sel;
            seen_wb         = WB_ALU_OUT;
            seen_st         = ST_D;
            exec_op         = ALU_NOP;
            @(posedge CLK);
            instr    <= test_instr[i]; // IR loads at the end of fetch
            alu_zero <= test_zero[i];
            alu_less <= test_less[i];
            @(negedge CLK);
            while (!ir_load) begin
                if (cycles == 1) ab_after = a_write && b_write;
                if (cycles == 2) begin
                    exec_op  = alu_op;
                    exec_aow = alu_out_write;
                end
                if (pc_write) begin
                    pc_writes++;
                    if (pc_sel == fetch_pc_sel) same_sel_writes++; // Jump must take the target
                end
                if (mdr_write) mdr_writes++;
                if (reg_write) begin
                    reg_writes++;
                    seen_wb = wb_sel;
                end
                if (mem_write) begin
                    mem_writes++;
                    seen_st = store_sel;
                end
                cycles++;
                @(negedge CLK);
            end

            check_value(test_name[i], "cycles", exp_cycles[i], cycles);
            check_value(test_name[i], "a_write and b_write after ir_load", 1, int'(ab_after));
            check_value(test_name[i], "alu_a_sel in fetch", int'(A_PC), int'(fetch_a_sel));
            check_value(test_name[i], "alu_b_sel in fetch", int'(B_FOUR), int'(fetch_b_sel));
            check_value(test_name[i], "alu_op in execute", int'(exp_op[i]), int'(exec_op));
            check_value(test_name[i], "alu_out_write in execute",
                        (exp_regw[i] + exp_memw[i] > 0) ? 1 : 0, int'(exec_aow));
            check_value(test_name[i], "pc_write pulses", exp_pcw[i], pc_writes);
            check_value(test_name[i], "jump pc_write with the PC + 4 pc_sel", 0, same_sel_writes);
            check_value(test_name[i], "mdr_write pulses", exp_mdr[i], mdr_writes);
            check_value(test_name[i], "reg_write pulses", exp_regw[i], reg_writes);
            check_value(test_name[i], "mem_write pulses", exp_memw[i], mem_writes);
            if (exp_regw[i] > 0) begin
                check_value(test_name[i], "wb_sel", int'(exp_wb[i]), int'(seen_wb));
            end
            if (exp_memw[i] > 0) begin
                check_value(test_name[i], "store_sel", int'(exp_st[i]), int'(seen_st));
            end
            report_test(test_name[i]);
        end

        $display("%0d tests run, %0d with errors", tests_run, failures);
        if (failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/control_unit_assertions.sv
`default_nettype none

module control_unit_assertions (
    input logic             CLK,
    input logic             RST,
    input ctrl_pkg::state_t state,
    input logic             ir_load,
    input logic             a_write,
    input logic             reg_write,
    input logic             mem_write,
    input logic             datapath_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    import ctrl_pkg::*;

    no_reg_mem_overlap: assert property (
        @(posedge CLK) disable iff (RST) !(reg_write && mem_write))
        else $error("reg_write and mem_write high in the same cycle");

    // Decode follows fetch directly
    load_then_decode: assert property (@(posedge CLK) disable iff (RST) ir_load |=> a_write)
        else $error("a_write did not follow ir_load");

    reset_pulse_state: assert property (@(posedge CLK) datapath_reset |-> state == st_reset)
        else $error("datapath_reset high outside the reset state");

endmodule

// FSM state and generator outputs meet at the top
bind control_unit control_unit_assertions assertions_inst (
    .CLK            (CLK),
    .RST            (RST),
    .state          (state),
    .ir_load        (ir_load),
    .a_write        (a_write),
    .reg_write      (reg_write),
    .mem_write      (mem_write),
    .datapath_reset (datapath_reset)
);

`default_nettype wire

// File: src/control_unit.sv
`default_nettype none

module control_unit (
    input  logic                 CLK,
    input  logic                 RST,
    input  riscv_isa_pkg::instr_t instr,
    input  logic                 alu_zero,
    input  logic                 alu_less,
    output logic                 pc_write,
    output logic                 pc_sel,
    output logic                 ir_load,
    output logic                 a_write,
    output logic                 b_write,
    output logic                 alu_out_write,
    output logic                 mdr_write,
    output logic                 mem_write,
    output logic                 reg_write,
    output logic                 datapath_reset,
    output ctrl_pkg::alu_op_t    alu_op,
    output ctrl_pkg::mux_a_sel_t alu_a_sel,
    output ctrl_pkg::mux_b_sel_t alu_b_sel,
    output ctrl_pkg::wb_sel_t    wb_sel,
    output ctrl_pkg::store_sel_t store_sel
);
    import ctrl_pkg::*;

    state_t state;

    decode_if dec_bus ();

    instr_decoder decoder_inst (
        .instr (instr),
        .dec   (dec_bus)
    );

    control_fsm fsm_inst (
        .CLK      (CLK),
        .RST      (RST),
        .alu_less (alu_less),
        .dec      (dec_bus),
        .state    (state)
    );

    ctrl_signal_gen signal_gen_inst (
        .state          (state),
        .alu_zero       (alu_zero),
        .dec            (dec_bus),
        .pc_write       (pc_write),
        .pc_sel         (pc_sel),
        .ir_load        (ir_load),
        .a_write        (a_write),
        .b_write        (b_write),
        .alu_out_write  (alu_out_write),
        .mdr_write      (mdr_write),
        .mem_write      (mem_write),
        .reg_write      (reg_write),
        .datapath_reset (datapath_reset),
        .alu_op         (alu_op),
        .alu_a_sel      (alu_a_sel),
        .alu_b_sel      (alu_b_sel),
        .wb_sel         (wb_sel),
        .store_sel      (store_sel)
    );

endmodule

`default_nettype wire

// File: sequencer/ctrl_signal_gen.sv
`default_nettype none

module ctrl_signal_gen (
    input  ctrl_pkg::state_t     state,
    input  logic                 alu_zero,
    decode_if.generator          dec,
    output logic                 pc_write,
    output logic                 pc_sel,
    output logic                 ir_load,
    output logic                 a_write,
    output logic                 b_write,
    output logic                 alu_out_write,
    output logic                 mdr_write,
    output logic                 mem_write,
    output logic                 reg_write,
    output logic                 datapath_reset,
    output ctrl_pkg::alu_op_t    alu_op,
    output ctrl_pkg::mux_a_sel_t alu_a_sel,
    output ctrl_pkg::mux_b_sel_t alu_b_sel,
    output ctrl_pkg::wb_sel_t    wb_sel,
    output ctrl_pkg::store_sel_t store_sel
);
    import ctrl_pkg::*;

    localparam logic PC_SEL_INC     = 1'b1; // ALU result, PC + 4 in fetch
    localparam logic PC_SEL_ALU_OUT = 1'b0; // Registered target

    logic branch_taken;

    assign branch_taken = (alu_zero == dec.branch_on_zero);

    always_comb begin
        pc_write       = 1'b0;
        pc_sel         = PC_SEL_INC;
        ir_load        = 1'b0;
        a_write        = 1'b0;
        b_write        = 1'b0;
        alu_out_write  = 1'b0;
        mdr_write      = 1'b0;
        mem_write      = 1'b0;
        reg_write      = 1'b0;
        datapath_reset = 1'b0;
        alu_op         = ALU_NOP;
        alu_a_sel      = A_PC;
        alu_b_sel      = B_REG;
        wb_sel         = WB_ALU_OUT;
        store_sel      = ST_D;

        case (state)
            st_reset: datapath_reset = 1'b1;
            st_fetch: begin
                ir_load   = 1'b1;
                pc_write  = 1'b1;
                alu_op    = ALU_ADD;
                alu_b_sel = B_FOUR;
            end
            st_decode: begin
                a_write       = 1'b1;
                b_write       = 1'b1;
                alu_out_write = 1'b1; // Branch target ahead of execute
                alu_op        = ALU_ADD;
                alu_b_sel     = B_SHIFTED_IMM;
            end
            st_execute: begin
                alu_op = dec.alu_op;
                case (dec.instr_class)
                    cls_r: begin
                        alu_a_sel     = A_REG;
                        alu_out_write = 1'b1;
                    end
                    cls_i_alu, cls_load, cls_store, cls_jalr: begin
                        alu_a_sel     = A_REG;
                        alu_b_sel     = B_IMM;
                        alu_out_write = 1'b1;
                    end
                    cls_lui: begin
                        alu_a_sel     = A_ZERO;
                        alu_b_sel     = B_IMM;
                        alu_out_write = 1'b1;
                    end
                    cls_branch: begin
                        alu_a_sel = A_REG; // rs1 - rs2
                        if (branch_taken) begin
                            pc_write = 1'b1;
                            pc_sel   = PC_SEL_ALU_OUT;
                        end
                    end
                    default: ;
                endcase
            end
            st_alu_writeback, st_lui_writeback: reg_write = 1'b1;
            st_set_one: begin
                reg_write = 1'b1;
                wb_sel    = WB_ONE;
            end
            st_set_zero: begin
                reg_write = 1'b1;
                wb_sel    = WB_ZERO;
            end
            st_load_read, st_store_read: mdr_write = 1'b1;
            st_load_writeback: begin
                reg_write = 1'b1;
                wb_sel    = dec.wb_load_sel;
            end
            st_store_write: begin
                mem_write = 1'b1;
                store_sel = dec.store_sel;
            end
            st_jalr_writeback: begin
                reg_write = 1'b1;
                wb_sel    = WB_PC; // Link before PC moves
                pc_write  = 1'b1;
                pc_sel    = PC_SEL_ALU_OUT;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: sequencer/control_fsm.sv
`default_nettype none

module control_fsm (
    input  logic             CLK,
    input  logic             RST,
    input  logic             alu_less,
    decode_if.sequencer      dec,
    output ctrl_pkg::state_t state
);
    import ctrl_pkg::*;

    state_t next_state;

    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_wait;
        case (state)
            st_reset:    next_state = st_wait;
            st_wait:     next_state = st_fetch;
            st_fetch:    next_state = st_decode;
            st_decode:   next_state = st_execute;
            st_execute: begin
                case (dec.instr_class)
                    cls_r, cls_i_alu: begin
                        if (dec.is_slt) begin
                            // ALU compares during execute
                            next_state = alu_less ? st_set_one : st_set_zero;
                        end else begin
                            next_state = st_alu_writeback;
                        end
                    end
                    cls_load:  next_state = st_load_wait;
                    cls_store: next_state = st_store_read;
                    cls_jalr:  next_state = st_jalr_writeback;
                    cls_lui:   next_state = st_lui_writeback;
                    default:   next_state = st_wait; // Branch done, illegal dropped
                endcase
            end
            st_load_wait:  next_state = st_load_read;
            st_load_read:  next_state = st_load_writeback;
            st_store_read: next_state = st_store_wait;
            st_store_wait: next_state = st_store_write;
            default:       next_state = st_wait; // All writebacks end here
        endcase
    end

endmodule

`default_nettype wire

// File: decode/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  riscv_isa_pkg::instr_t instr,
    decode_if.decoder             dec
);
    import riscv_isa_pkg::*;
    import ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec.instr_class = cls_illegal;
        dec.alu_op      = ALU_NOP;
        dec.is_slt      = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == FUNCT7_BASE) begin
                    dec.instr_class = cls_r;
                    case (funct3)
                        F3_ADD:  dec.alu_op = ALU_ADD;
                        F3_AND:  dec.alu_op = ALU_AND;
                        F3_SLT: begin
                            dec.alu_op = ALU_SLT;
                            dec.is_slt = 1'b1;
                        end
                        default: dec.instr_class = cls_illegal;
                    endcase
                end else if (funct7 == FUNCT7_SUB && funct3 == F3_ADD) begin
                    dec.instr_class = cls_r;
                    dec.alu_op      = ALU_SUB;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    dec.instr_class = cls_i_alu;
                    dec.alu_op      = ALU_ADD;
                end else if (funct3 == F3_SLT) begin
                    dec.instr_class = cls_i_alu;
                    dec.alu_op      = ALU_SLT;
                    dec.is_slt      = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (funct3 != 3'b111) begin // Only 111 is not a load width
                    dec.instr_class = cls_load;
                    dec.alu_op      = ALU_ADD; // Address rs1 + imm
                end
            end
            OPC_STORE: begin
                if (funct3 inside {F3_SD, F3_SW, F3_SH, F3_SB}) begin
                    dec.instr_class = cls_store;
                    dec.alu_op      = ALU_ADD;
                end
            end
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    dec.instr_class = cls_branch;
                    dec.alu_op      = ALU_SUB; // Compare through zero flag
                end
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    dec.instr_class = cls_jalr;
                    dec.alu_op      = ALU_ADD;
                end
            end
            OPC_LUI: begin
                dec.instr_class = cls_lui;
                dec.alu_op      = ALU_ADD; // Zero + upper immediate
            end
            default: ;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_LB:   dec.wb_load_sel = WB_LB;
            F3_LH:   dec.wb_load_sel = WB_LH;
            F3_LW:   dec.wb_load_sel = WB_LW;
            F3_LBU:  dec.wb_load_sel = WB_LBU;
            F3_LHU:  dec.wb_load_sel = WB_LHU;
            F3_LWU:  dec.wb_load_sel = WB_LWU;
            default: dec.wb_load_sel = WB_LD;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_SW:   dec.store_sel = ST_W;
            F3_SH:   dec.store_sel = ST_H;
            F3_SB:   dec.store_sel = ST_B;
            default: dec.store_sel = ST_D;
        endcase
    end

    assign dec.branch_on_zero = (funct3 == F3_BEQ);

endmodule

`default_nettype wire

// File: common/decode_if.sv
`default_nettype none

interface decode_if;
    import ctrl_pkg::*;

    instr_class_t instr_class;
    alu_op_t      alu_op;
    logic         is_slt;         // slt or slti
    wb_sel_t      wb_load_sel;
    store_sel_t   store_sel;
    logic         branch_on_zero; // 1 for beq

    modport decoder (output instr_class, alu_op, is_slt, wb_load_sel, store_sel,
                     branch_on_zero);
    modport sequencer (input instr_class, is_slt);
    modport generator (input instr_class, alu_op, wb_load_sel, store_sel, branch_on_zero);

endinterface

`default_nettype wire

// File: common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [4:0] {
        st_reset,
        st_wait,
        st_fetch,
        st_decode,
        st_execute,
        st_alu_writeback,
        st_set_one,
        st_set_zero,
        st_load_wait,
        st_load_read,
        st_load_writeback,
        st_store_read,
        st_store_wait,
        st_store_write,
        st_jalr_writeback,
        st_lui_writeback
    } state_t;

    typedef enum logic [2:0] {
        cls_r,
        cls_i_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_jalr,
        cls_lui,
        cls_illegal
    } instr_class_t;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_NOP = 3'b000;
    localparam alu_op_t ALU_ADD = 3'b001;
    localparam alu_op_t ALU_SUB = 3'b010;
    localparam alu_op_t ALU_AND = 3'b011;
    localparam alu_op_t ALU_SLT = 3'b110;

    // Register file data source
    typedef logic [3:0] wb_sel_t;
    localparam wb_sel_t WB_ALU_OUT = 4'b0000;
    localparam wb_sel_t WB_ONE     = 4'b0010;
    localparam wb_sel_t WB_ZERO    = 4'b0011;
    localparam wb_sel_t WB_PC      = 4'b0100;
    localparam wb_sel_t WB_LD      = 4'b0101;
    localparam wb_sel_t WB_LB      = 4'b0110;
    localparam wb_sel_t WB_LH      = 4'b0111;
    localparam wb_sel_t WB_LW      = 4'b1000;
    localparam wb_sel_t WB_LBU     = 4'b1001;
    localparam wb_sel_t WB_LHU     = 4'b1010;
    localparam wb_sel_t WB_LWU     = 4'b1011;

    typedef logic [1:0] store_sel_t;
    localparam store_sel_t ST_D = 2'b00;
    localparam store_sel_t ST_W = 2'b01;
    localparam store_sel_t ST_H = 2'b10;
    localparam store_sel_t ST_B = 2'b11;

    typedef logic [1:0] mux_a_sel_t;
    localparam mux_a_sel_t A_PC   = 2'b00;
    localparam mux_a_sel_t A_REG  = 2'b01;
    localparam mux_a_sel_t A_ZERO = 2'b11;

    typedef logic [2:0] mux_b_sel_t;
    localparam mux_b_sel_t B_REG         = 3'b000;
    localparam mux_b_sel_t B_FOUR        = 3'b001;
    localparam mux_b_sel_t B_IMM         = 3'b010;
    localparam mux_b_sel_t B_SHIFTED_IMM = 3'b011; // Branch offset, already scaled

endpackage

`default_nettype wire

// File: common/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // ALU functions, shared by OP and OP-IMM
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_AND = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_LWU = 3'b110;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;
    localparam funct3_t F3_SD = 3'b011;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_JALR = 3'b000;

    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    localparam funct7_t FUNCT7_SUB  = 7'b0100000; // Selects sub over add

endpackage

`default_nettype wire
